//--- src/socMapPkg.sv
// shared address map and bus types; byte enables unsupported, sizes are in bytes, word aligned
package socMapPkg;

    // device base addresses
    localparam logic [31:0] ramBase    = 32'h0000_0000;
    localparam logic [31:0] randomBase = 32'h0000_5000;
    localparam logic [31:0] timerBase  = 32'h0000_5100;

    // device window sizes in bytes
    // ram size comes from the top-level ramAddrBits
    localparam logic [31:0] randomSize = 32'h0000_0004;
    localparam logic [31:0] timerSize  = 32'h0000_0010;

    // timer register word offsets
    localparam logic [1:0] timerCountReg   = 2'd0;
    localparam logic [1:0] timerCompareReg = 2'd1;
    // control: bit 0 enable, bit 1 match flag
    localparam logic [1:0] timerControlReg = 2'd2;

    // galois feedback mask for the random source
    localparam logic [31:0] lfsrTaps      = 32'h8020_0003;
    localparam logic [31:0] lfsrResetSeed = 32'h0000_0001;

    // master request, single-cycle strobes
    typedef struct packed {
        logic        read;
        logic        write;
        logic [31:0] address;
        logic [31:0] writeData;
    } busReq_t;

    // merged response back to the master
    typedef struct packed {
        logic        valid;
        logic [31:0] data;
    } busRsp_t;

    // request routed to one device
    // offset is a word offset already masked to the device window
    typedef struct packed {
        logic        read;
        logic        write;
        logic [11:0] offset;
        logic [31:0] writeData;
    } devReq_t;

    // one device's registered response
    typedef struct packed {
        logic        valid;
        logic [31:0] data;
    } devRsp_t;

endpackage

//--- src/addressDecoder.sv
// combinational decode of one strobe to at most one device; ramAddrBits above 12 is not supported
`timescale 1ns/1ps

module addressDecoder #(
    parameter int ramAddrBits = 10
) (
    input  socMapPkg::busReq_t busReq,
    output socMapPkg::devReq_t ramReq,
    output socMapPkg::devReq_t timerReq,
    output socMapPkg::devReq_t randomReq,
    output logic               unmappedRead
);

    // ram window in bytes, one word per entry
    localparam logic [31:0] ramSize = 32'h4 << ramAddrBits;

    logic ramHit;
    logic timerHit;
    logic randomHit;
    logic anyHit;

    // inclusive byte range check
    function automatic logic inRange(
        input logic [31:0] addr,
        input logic [31:0] base,
        input logic [31:0] size
    );
        logic [31:0] last;
        last = base + size - 32'd1;
        return (addr >= base) && (addr <= last);
    endfunction

    // gate the strobes and cut the word offset down to the window
    function automatic socMapPkg::devReq_t routeReq(
        input socMapPkg::busReq_t req,
        input logic               hit,
        input logic [31:0]        size
    );
        socMapPkg::devReq_t dev;
        logic [31:0]        wordCount;
        logic [11:0]        wordMask;
        wordCount     = size >> 2;
        wordMask      = 12'(wordCount - 32'd1);
        dev.read      = req.read & hit;
        dev.write     = req.write & hit;
        dev.offset    = req.address[13:2] & wordMask;
        dev.writeData = req.writeData;
        return dev;
    endfunction

    always_comb begin
        // windows do not overlap, so one hit at most
        ramHit    = inRange(busReq.address, socMapPkg::ramBase, ramSize);
        timerHit  = inRange(busReq.address, socMapPkg::timerBase, socMapPkg::timerSize);
        randomHit = inRange(busReq.address, socMapPkg::randomBase, socMapPkg::randomSize);
        anyHit    = ramHit | timerHit | randomHit;
    end

    always_comb begin
        ramReq    = routeReq(busReq, ramHit, ramSize);
        timerReq  = routeReq(busReq, timerHit, socMapPkg::timerSize);
        randomReq = routeReq(busReq, randomHit, socMapPkg::randomSize);
    end

    // no device claims it
    // writes to a hole simply vanish, reads get a zero reply later
    assign unmappedRead = busReq.read & ~anyHit;

endmodule

//--- src/scratchRam.sv
// single-port word RAM, read data one cycle after the strobe; contents undefined after power-up
`timescale 1ns/1ps

module scratchRam #(
    parameter int ramAddrBits = 10
) (
    input  logic               clk,
    input  logic               reset,
    input  socMapPkg::devReq_t req,
    output socMapPkg::devRsp_t rsp
);

    localparam int ramWords = 2 ** ramAddrBits;

    logic [31:0]            mem [ramWords];
    logic [ramAddrBits-1:0] wordAddr;
    logic [31:0]            readData;
    logic                   readValid;

    // decoder already masked the offset
    assign wordAddr = req.offset[ramAddrBits-1:0];

    // array and read data register
    always_ff @(posedge clk) begin
        if (req.write) begin
            mem[wordAddr] <= req.writeData;
        end
        if (req.read) begin
            readData <= mem[wordAddr];
        end
    end

    // valid pulse follows the read strobe
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            readValid <= 1'b0;
        end else begin
            readValid <= req.read;
        end
    end

    always_comb begin
        rsp.valid = readValid;
        rsp.data  = readData;
    end

endmodule

//--- src/timerBlock.sv
// free-running 32-bit timer with compare; match flag only sets while enabled and wraps at 2^32
`timescale 1ns/1ps

module timerBlock (
    input  logic               clk,
    input  logic               reset,
    input  socMapPkg::devReq_t req,
    output socMapPkg::devRsp_t rsp
);

    logic [31:0] count;
    logic [31:0] compare;
    logic        enable;
    logic        matchFlag;
    logic [1:0]  regSel;
    logic        matchHit;
    logic [31:0] readData;
    logic        readValid;

    // four word window, only the low bits matter
    assign regSel = req.offset[1:0];

    // equality only counts while running
    assign matchHit = enable & (count == compare);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count     <= 32'd0;
            compare   <= 32'd0;
            enable    <= 1'b0;
            matchFlag <= 1'b0;
        end else begin
            // bus load of the counter beats the increment
            if (req.write && regSel == socMapPkg::timerCountReg) begin
                count <= req.writeData;
            end else if (enable) begin
                count <= count + 32'd1;
            end
            if (req.write && regSel == socMapPkg::timerCompareReg) begin
                compare <= req.writeData;
            end
            // sticky flag, write 1 to bit 1 to clear
            if (req.write && regSel == socMapPkg::timerControlReg) begin
                enable    <= req.writeData[0];
                matchFlag <= (matchFlag & ~req.writeData[1]) | matchHit;
            end else begin
                matchFlag <= matchFlag | matchHit;
            end
        end
    end

    // snapshot of the register in the strobe cycle
    always_ff @(posedge clk) begin
        if (req.read) begin
            case (regSel)
                socMapPkg::timerCountReg:   readData <= count;
                socMapPkg::timerCompareReg: readData <= compare;
                socMapPkg::timerControlReg: readData <= {30'd0, matchFlag, enable};
                default:                    readData <= 32'd0;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            readValid <= 1'b0;
        end else begin
            readValid <= req.read;
        end
    end

    always_comb begin
        rsp.valid = readValid;
        rsp.data  = readData;
    end

endmodule

//--- src/randomSource.sv
// 32-bit Galois LFSR stepped once per read; not suitable for cryptographic use
`timescale 1ns/1ps

module randomSource (
    input  logic               clk,
    input  logic               reset,
    input  socMapPkg::devReq_t req,
    output socMapPkg::devRsp_t rsp
);

    logic [31:0] state;
    logic [31:0] nextState;
    logic [31:0] readData;
    logic        readValid;

    // shift right, fold taps back in when a one falls out
    assign nextState = {1'b0, state[31:1]} ^ (state[0] ? socMapPkg::lfsrTaps : 32'd0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= socMapPkg::lfsrResetSeed;
            readValid <= 1'b0;
        end else begin
            readValid <= req.read;
            if (req.write) begin
                // all-zero state would lock up
                state <= (req.writeData == 32'd0) ? socMapPkg::lfsrResetSeed : req.writeData;
            end else if (req.read) begin
                state <= nextState;
            end
        end
    end

    // current value goes out, successor stays behind
    always_ff @(posedge clk) begin
        if (req.read) begin
            readData <= state;
        end
    end

    always_comb begin
        rsp.valid = readValid;
        rsp.data  = readData;
    end

endmodule

//--- src/readReturn.sv
// merges device replies into one port; relies on equal one-cycle latency so valids never overlap
`timescale 1ns/1ps

module readReturn (
    input  logic               clk,
    input  logic               reset,
    input  socMapPkg::devRsp_t ramRsp,
    input  socMapPkg::devRsp_t timerRsp,
    input  socMapPkg::devRsp_t randomRsp,
    input  logic               unmappedRead,
    output socMapPkg::busRsp_t busRsp
);

    logic       defaultValid;
    logic [2:0] validBus;

    // hole reads get the same one-cycle delay as a device
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            defaultValid <= 1'b0;
        end else begin
            defaultValid <= unmappedRead;
        end
    end

    assign validBus = {ramRsp.valid, timerRsp.valid, randomRsp.valid};

    always_comb begin
        // one-hot pick, anything else reads as zero
        case (validBus)
            3'b100:  busRsp.data = ramRsp.data;
            3'b010:  busRsp.data = timerRsp.data;
            3'b001:  busRsp.data = randomRsp.data;
            default: busRsp.data = 32'd0;
        endcase
        // unmapped reply rides on the zero default
        busRsp.valid = (|validBus) | defaultValid;
    end

endmodule

//--- src/socInterconnectTop.sv
// peripheral interconnect top; no wait request, every read answers exactly one cycle later
`timescale 1ns/1ps

module socInterconnectTop #(
    parameter int ramAddrBits = 10
) (
    input  logic               clk,
    input  logic               reset,
    input  socMapPkg::busReq_t busReq,
    output socMapPkg::busRsp_t busRsp
);

    // decoder to devices
    socMapPkg::devReq_t ramReq;
    socMapPkg::devReq_t timerReq;
    socMapPkg::devReq_t randomReq;
    logic               unmappedRead;

    // devices to return stage
    socMapPkg::devRsp_t ramRsp;
    socMapPkg::devRsp_t timerRsp;
    socMapPkg::devRsp_t randomRsp;

    // decode stage
    addressDecoder #(
        .ramAddrBits (ramAddrBits)
    ) i_addressDecoder (
        .busReq       (busReq),
        .ramReq       (ramReq),
        .timerReq     (timerReq),
        .randomReq    (randomReq),
        .unmappedRead (unmappedRead)
    );

    // scratch memory
    scratchRam #(
        .ramAddrBits (ramAddrBits)
    ) i_scratchRam (
        .clk   (clk),
        .reset (reset),
        .req   (ramReq),
        .rsp   (ramRsp)
    );

    // timer
    timerBlock i_timerBlock (
        .clk   (clk),
        .reset (reset),
        .req   (timerReq),
        .rsp   (timerRsp)
    );

    // random number source
    randomSource i_randomSource (
        .clk   (clk),
        .reset (reset),
        .req   (randomReq),
        .rsp   (randomRsp)
    );

    // result merge
    // unmapped strobe delayed inside to line up with devices
    readReturn i_readReturn (
        .clk          (clk),
        .reset        (reset),
        .ramRsp       (ramRsp),
        .timerRsp     (timerRsp),
        .randomRsp    (randomRsp),
        .unmappedRead (unmappedRead),
        .busRsp       (busRsp)
    );

endmodule

//--- test/clockGen.sv
// 8 ns testbench clock; reset is high from time zero and drops on a falling edge
`timescale 1ns/1ps

module clockGen #(
    parameter int resetCycles = 8
) (
    output logic clk,
    output logic reset
);

    // half period of 4 ns
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // release away from the rising edge
    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

//--- test/socTb.sv
// directed testbench for the interconnect; assumes ramAddrBits 10 and one-cycle read latency
`timescale 1ns/1ps

module socTb;

    localparam int ramAddrBits  = 10;
    localparam int resetCycles  = 8;
    // bus operations over all tests, timer wait counted apart
    localparam int busOps       = 220;
    localparam int timerWaitMax = 64;
    localparam int watchdogCycles = busOps * 4 + timerWaitMax + resetCycles + 50;
    // stimulus generator mask, independent of the DUT source
    localparam logic [31:0] stimTaps = 32'hB4BC_D35C;

    logic               clk;
    logic               reset;
    socMapPkg::busReq_t busReq;
    socMapPkg::busRsp_t busRsp;

    int          errorCount = 0;
    int          checkCount = 0;
    logic [31:0] stimState  = 32'h1a7345be;
    logic [31:0] ramModel [2 ** ramAddrBits];
    logic [31:0] randomModel;
    // written word addresses, in write order
    logic [31:0] ramAddrs [$];
    // reads waiting for the next burst
    logic [31:0] pendAddr [$];
    logic [31:0] pendExpect [$];

    clockGen #(
        .resetCycles (resetCycles)
    ) i_clockGen (
        .clk   (clk),
        .reset (reset)
    );

    socInterconnectTop #(
        .ramAddrBits (ramAddrBits)
    ) i_dut (
        .clk    (clk),
        .reset  (reset),
        .busReq (busReq),
        .busRsp (busRsp)
    );

    // one galois step per stimulus bit
    function automatic logic stimBit();
        logic outBit;
        outBit    = stimState[0];
        stimState = {1'b0, stimState[31:1]} ^ (outBit ? stimTaps : 32'd0);
        return outBit;
    endfunction

    function automatic logic [31:0] stimBits(input int count);
        logic [31:0] value;
        int          i;
        value = 32'd0;
        for (i = 0; i < count; i++) begin
            value = {value[30:0], stimBit()};
        end
        return value;
    endfunction

    // expected successor of the random source state
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? socMapPkg::lfsrTaps : 32'd0);
    endfunction

    function automatic logic [31:0] timerAddr(input logic [1:0] regIdx);
        return socMapPkg::timerBase + {28'd0, regIdx, 2'b00};
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        checkCount++;
        assert (got === expected) else begin
            errorCount++;
            $display("[FAIL] %s: got %h, expected %h", name, got, expected);
        end
    endtask

    task automatic busWrite(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk);
        busReq.read      = 1'b0;
        busReq.write     = 1'b1;
        busReq.address   = addr;
        busReq.writeData = data;
        // only the ram window keeps data
        if (addr < (32'h4 << ramAddrBits)) begin
            ramModel[addr[ramAddrBits+1:2]] = data;
        end
        @(negedge clk);
        busReq.write = 1'b0;
    endtask

    task automatic queueRead(input logic [31:0] addr, input logic [31:0] expected);
        pendAddr.push_back(addr);
        pendExpect.push_back(expected);
    endtask

    // back-to-back strobes, each answer sampled one cycle later
    task automatic readBurst();
        int n;
        int i;
        n = pendAddr.size();
        for (i = 0; i <= n; i++) begin
            @(negedge clk);
            if (i > 0) begin
                checkCount++;
                assert (busRsp.valid === 1'b1) else begin
                    errorCount++;
                    $display("read of %h got no valid response in the next cycle",
                             pendAddr[i-1]);
                end
                checkValue($sformatf("busRsp.data @%h", pendAddr[i-1]), busRsp.data,
                           pendExpect[i-1]);
            end
            busReq.write = 1'b0;
            busReq.read  = (i < n);
            if (i < n) begin
                busReq.address = pendAddr[i];
            end
        end
        // nothing should trail the last answer
        @(negedge clk);
        checkCount++;
        assert (busRsp.valid === 1'b0) else begin
            errorCount++;
            $display("response valid seen with no read outstanding");
        end
        pendAddr.delete();
        pendExpect.delete();
    endtask

    task automatic busRead(input logic [31:0] addr, input logic [31:0] expected);
        queueRead(addr, expected);
        readBurst();
    endtask

    // bursts of one to four reads over all written words
    task automatic readBackRam();
        int idx;
        int burstLen;
        int j;
        idx = 0;
        while (idx < ramAddrs.size()) begin
            burstLen = 1 + int'(stimBits(2));
            for (j = 0; j < burstLen && idx < ramAddrs.size(); j++) begin
                queueRead(ramAddrs[idx] << 2, ramModel[ramAddrs[idx]]);
                idx++;
            end
            readBurst();
        end
    endtask

    task automatic ramWritesAndReads();
        logic [31:0] wordAddr;
        int          i;
        for (i = 0; i < 64; i++) begin
            wordAddr = stimBits(ramAddrBits);
            ramAddrs.push_back(wordAddr);
            busWrite(wordAddr << 2, stimBits(32));
        end
        readBackRam();
    endtask

    task automatic unmappedAccess();
        busRead(32'h0000_4000, 32'd0);
        busRead(32'h0300_0000, 32'd0);
        busRead(32'hFFFF_FFFC, 32'd0);
        // these would alias onto written ram words if decode leaked
        busWrite(32'h0000_4000 | (ramAddrs[0] << 2), stimBits(32));
        busWrite(32'h0300_0000 | (ramAddrs[1] << 2), stimBits(32));
        readBackRam();
    endtask

    task automatic timerRegisters();
        logic [31:0] countVal;
        logic [31:0] compareVal;
        // still untouched since reset
        busRead(timerAddr(socMapPkg::timerControlReg), 32'd0);
        countVal   = stimBits(32);
        compareVal = stimBits(32);
        busWrite(timerAddr(socMapPkg::timerCountReg), countVal);
        busWrite(timerAddr(socMapPkg::timerCompareReg), compareVal);
        busRead(timerAddr(socMapPkg::timerCountReg), countVal);
        busRead(timerAddr(socMapPkg::timerCompareReg), compareVal);
    endtask

    task automatic timerMatch();
        logic [31:0] target;
        target = 32'd16 + stimBits(5);
        busWrite(timerAddr(socMapPkg::timerCompareReg), target);
        busWrite(timerAddr(socMapPkg::timerCountReg), 32'd0);
        busWrite(timerAddr(socMapPkg::timerControlReg), 32'h1);
        repeat (target + 8) @(negedge clk);
        // enable plus sticky flag
        busRead(timerAddr(socMapPkg::timerControlReg), 32'h3);
        busWrite(timerAddr(socMapPkg::timerControlReg), 32'h3);
        busRead(timerAddr(socMapPkg::timerControlReg), 32'h1);
        busWrite(timerAddr(socMapPkg::timerControlReg), 32'h0);
    endtask

    task automatic randomSequence();
        logic [31:0] seed;
        int          i;
        randomModel = socMapPkg::lfsrResetSeed;
        for (i = 0; i < 4; i++) begin
            queueRead(socMapPkg::randomBase, randomModel);
            randomModel = lfsrStep(randomModel);
        end
        readBurst();
        seed = stimBits(32);
        busWrite(socMapPkg::randomBase, seed);
        // zero seed falls back to the reset seed
        randomModel = (seed == 32'd0) ? socMapPkg::lfsrResetSeed : seed;
        busRead(socMapPkg::randomBase, randomModel);
        randomModel = lfsrStep(randomModel);
        busRead(socMapPkg::randomBase, randomModel);
        randomModel = lfsrStep(randomModel);
    endtask

    task automatic pipelinedReads();
        queueRead(ramAddrs[5] << 2, ramModel[ramAddrs[5]]);
        queueRead(socMapPkg::randomBase, randomModel);
        randomModel = lfsrStep(randomModel);
        queueRead(32'hFFFF_FFFC, 32'd0);
        readBurst();
    endtask

    // hang guard sized from the test lengths
    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, tests did not complete", watchdogCycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        busReq = '0;
        wait (reset === 1'b0);
        ramWritesAndReads();
        unmappedAccess();
        timerRegisters();
        timerMatch();
        randomSequence();
        pipelinedReads();
        @(negedge clk);
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- socBus.f
src/socMapPkg.sv
src/addressDecoder.sv
src/scratchRam.sv
src/timerBlock.sv
src/randomSource.sv
src/readReturn.sv
src/socInterconnectTop.sv
test/clockGen.sv
test/socTb.sv

//--- Bender.yml
package:
  name: socBus

sources:
  - src/socMapPkg.sv
  - src/addressDecoder.sv
  - src/scratchRam.sv
  - src/timerBlock.sv
  - src/randomSource.sv
  - src/readReturn.sv
  - src/socInterconnectTop.sv
  - target: test
    files:
      - test/clockGen.sv
      - test/socTb.sv
